// File: hw/rv_params.svh
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

`define RV_RESET_PC      32'h0000_0000
`define RV_MEM_WORDS     1024
`define RV_TRACE_CREDITS 4

`define RV_CSR_MSTATUS   12'h300
`define RV_CSR_MTVEC     12'h305
`define RV_CSR_MEPC      12'h341
`define RV_CSR_MCAUSE    12'h342

`endif

// File: hw/rv_pkg.sv
`default_nettype none
`include "rv_params.svh"

package rv_pkg;

  localparam int unsigned RV_MEM_AW = $clog2(`RV_MEM_WORDS);

  typedef enum logic [5:0] {
    OP_ILLEGAL, OP_LUI, OP_AUIPC, OP_JAL, OP_JALR,
    OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
    OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU,
    OP_SB, OP_SH, OP_SW,
    OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI, OP_ANDI,
    OP_SLLI, OP_SRLI, OP_SRAI,
    OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU, OP_XOR,
    OP_SRL, OP_SRA, OP_OR, OP_AND,
    OP_CSRRW, OP_CSRRS, OP_ECALL, OP_MRET, OP_EBREAK
  } rv_op_e;

  typedef struct packed {
    rv_op_e      op;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [31:0] imm;
    logic [11:0] csr;
    logic        rd_wen;   // Already cleared for x0
    logic        is_load;
    logic        is_store;
  } rv_dec_t;

  typedef struct packed {
    logic                 valid;
    logic [RV_MEM_AW-1:0] addr;   // Word address
    logic [31:0]          data;
  } rv_load_t;

  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] inst;
    logic        rd_wen;
    logic [4:0]  rd;
    logic [31:0] rd_wdata;
    logic        st_en;
    logic [31:0] st_addr;
    logic [31:0] st_wdata;   // Lane aligned
    logic [3:0]  st_mask;
    logic        trap;       // ECALL or MRET
  } rv_trace_t;

endpackage

`default_nettype wire

// File: hw/rv_mem.sv
`default_nettype none
`timescale 1ns/1ps
`include "rv_params.svh"

module rv_mem import rv_pkg::*; (
  input  logic        clk,
  input  rv_load_t    load,
  input  logic [31:0] pc,
  output logic [31:0] inst,
  input  logic [31:0] d_addr,
  output logic [31:0] d_rdata,
  input  logic [31:0] d_wdata,
  input  logic [3:0]  d_mask,
  input  logic        d_wen
);

  logic [31:0]          mem [`RV_MEM_WORDS];
  logic [RV_MEM_AW-1:0] i_idx;
  logic [RV_MEM_AW-1:0] d_idx;

  assign i_idx = pc[RV_MEM_AW+1:2];       // Upper bits wrap
  assign d_idx = d_addr[RV_MEM_AW+1:2];

  assign inst    = mem[i_idx];
  assign d_rdata = mem[d_idx];

  always_ff @(posedge clk) begin
    if (load.valid) begin
      mem[load.addr] <= load.data;
    end else if (d_wen) begin
      for (int b = 0; b < 4; b++) begin
        if (d_mask[b]) begin
          mem[d_idx][8*b +: 8] <= d_wdata[8*b +: 8];
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/rv_decode.sv
`default_nettype none
`timescale 1ns/1ps

module rv_decode import rv_pkg::*; (
  input  logic [31:0] inst,
  output rv_dec_t     dec
);

  logic [6:0]  opcode;
  logic [6:0]  funct7;
  logic [2:0]  funct3;
  logic [31:0] imm_i, imm_s, imm_b, imm_u, imm_j;
  rv_op_e      op;

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];

  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {inst[31:12], 12'b0};
  assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    op = OP_ILLEGAL;
    case (opcode)
      7'b0110111: op = OP_LUI;
      7'b0010111: op = OP_AUIPC;
      7'b1101111: op = OP_JAL;
      7'b1100111: if (funct3 == 3'b000) op = OP_JALR;
      7'b1100011: begin
        case (funct3)
          3'b000:  op = OP_BEQ;
          3'b001:  op = OP_BNE;
          3'b100:  op = OP_BLT;
          3'b101:  op = OP_BGE;
          3'b110:  op = OP_BLTU;
          3'b111:  op = OP_BGEU;
          default: op = OP_ILLEGAL;
        endcase
      end
      7'b0000011: begin
        case (funct3)
          3'b000:  op = OP_LB;
          3'b001:  op = OP_LH;
          3'b010:  op = OP_LW;
          3'b100:  op = OP_LBU;
          3'b101:  op = OP_LHU;
          default: op = OP_ILLEGAL;
        endcase
      end
      7'b0100011: begin
        case (funct3)
          3'b000:  op = OP_SB;
          3'b001:  op = OP_SH;
          3'b010:  op = OP_SW;
          default: op = OP_ILLEGAL;
        endcase
      end
      7'b0010011: begin
        case (funct3)
          3'b000: op = OP_ADDI;
          3'b010: op = OP_SLTI;
          3'b011: op = OP_SLTIU;
          3'b100: op = OP_XORI;
          3'b110: op = OP_ORI;
          3'b111: op = OP_ANDI;
          3'b001: if (funct7 == 7'b0000000) op = OP_SLLI;
          3'b101: begin
            if (funct7 == 7'b0000000) op = OP_SRLI;
            else if (funct7 == 7'b0100000) op = OP_SRAI;
          end
          default: op = OP_ILLEGAL;
        endcase
      end
      7'b0110011: begin
        case ({funct7, funct3})
          10'b0000000_000: op = OP_ADD;
          10'b0100000_000: op = OP_SUB;
          10'b0000000_001: op = OP_SLL;
          10'b0000000_010: op = OP_SLT;
          10'b0000000_011: op = OP_SLTU;
          10'b0000000_100: op = OP_XOR;
          10'b0000000_101: op = OP_SRL;
          10'b0100000_101: op = OP_SRA;
          10'b0000000_110: op = OP_OR;
          10'b0000000_111: op = OP_AND;
          default:         op = OP_ILLEGAL;
        endcase
      end
      7'b1110011: begin
        if (inst == 32'h0000_0073) op = OP_ECALL;
        else if (inst == 32'h0010_0073) op = OP_EBREAK;
        else if (inst == 32'h3020_0073) op = OP_MRET;
        else if (funct3 == 3'b001) op = OP_CSRRW;
        else if (funct3 == 3'b010) op = OP_CSRRS;
      end
      default: op = OP_ILLEGAL;
    endcase
  end

  always_comb begin
    dec     = '0;
    dec.op  = op;
    dec.rd  = inst[11:7];
    dec.rs1 = inst[19:15];
    dec.rs2 = inst[24:20];
    dec.csr = inst[31:20];
    case (op)
      OP_LUI, OP_AUIPC:                                   dec.imm = imm_u;
      OP_JAL:                                             dec.imm = imm_j;
      OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU:   dec.imm = imm_b;
      OP_SB, OP_SH, OP_SW:                                dec.imm = imm_s;
      default:                                            dec.imm = imm_i;
    endcase
    dec.is_load  = op inside {OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU};
    dec.is_store = op inside {OP_SB, OP_SH, OP_SW};
    dec.rd_wen   = !(op inside {OP_ILLEGAL, OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU,
                                OP_BGEU, OP_SB, OP_SH, OP_SW, OP_ECALL, OP_MRET,
                                OP_EBREAK}) && (inst[11:7] != 5'd0);
  end

endmodule

`default_nettype wire

// File: hw/rv_regfile.sv
`default_nettype none
`timescale 1ns/1ps

module rv_regfile (
  input  logic        clk,
  input  logic        rst_n,
  input  logic [4:0]  raddr1,
  input  logic [4:0]  raddr2,
  output logic [31:0] rdata1,
  output logic [31:0] rdata2,
  input  logic [4:0]  waddr,
  input  logic [31:0] wdata,
  input  logic        wen
);

  logic [31:0] regs [1:31];   // No storage for x0

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && waddr != 5'd0) begin
      regs[waddr] <= wdata;
    end
  end

  assign rdata1 = (raddr1 == 5'd0) ? 32'd0 : regs[raddr1];
  assign rdata2 = (raddr2 == 5'd0) ? 32'd0 : regs[raddr2];

endmodule

`default_nettype wire

// File: hw/rv_csr.sv
`default_nettype none
`timescale 1ns/1ps
`include "rv_params.svh"

module rv_csr import rv_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  rv_dec_t     dec,
  input  logic [31:0] rs1_data,
  input  logic [31:0] pc,
  input  logic        commit,
  output logic [31:0] csr_rdata,
  output logic [31:0] mepc,
  output logic [31:0] mtvec
);

  logic [31:0] mstatus;
  logic [31:0] mcause;
  logic [31:0] wval;
  logic        is_csr;

  assign is_csr = (dec.op == OP_CSRRW) || (dec.op == OP_CSRRS);

  always_comb begin
    case (dec.csr)
      `RV_CSR_MSTATUS: csr_rdata = mstatus;
      `RV_CSR_MTVEC:   csr_rdata = mtvec;
      `RV_CSR_MEPC:    csr_rdata = mepc;
      `RV_CSR_MCAUSE:  csr_rdata = mcause;
      default:         csr_rdata = 32'd0;
    endcase
  end

  assign wval = (dec.op == OP_CSRRW) ? rs1_data : (csr_rdata | rs1_data);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      mstatus <= 32'h0000_1800;   // MPP = M
      mtvec   <= '0;
      mepc    <= '0;
      mcause  <= '0;
    end else if (commit) begin
      if (dec.op == OP_ECALL) begin
        mepc           <= pc;       // Handler advances it
        mcause         <= 32'd11;   // Environment call from M
        mstatus[7]     <= mstatus[3];
        mstatus[3]     <= 1'b0;
        mstatus[12:11] <= 2'b11;
      end else if (dec.op == OP_MRET) begin
        mstatus[3] <= mstatus[7];
        mstatus[7] <= 1'b1;
      end else if (is_csr) begin
        case (dec.csr)
          `RV_CSR_MSTATUS: mstatus <= wval;
          `RV_CSR_MTVEC:   mtvec   <= wval;
          `RV_CSR_MEPC:    mepc    <= wval;
          `RV_CSR_MCAUSE:  mcause  <= wval;
          default: ;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/rv_exec.sv
`default_nettype none
`timescale 1ns/1ps
`include "rv_params.svh"

module rv_exec import rv_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        start,
  input  logic        stall,
  input  logic [31:0] inst,
  input  rv_dec_t     dec,
  input  logic [31:0] rs1_data,
  input  logic [31:0] rs2_data,
  input  logic [31:0] csr_rdata,
  input  logic [31:0] mepc,
  input  logic [31:0] mtvec,
  input  logic [31:0] d_rdata,
  output logic [31:0] pc,
  output logic [31:0] d_addr,
  output logic [31:0] d_wdata,
  output logic [3:0]  d_mask,
  output logic        d_wen,
  output logic [31:0] rd_wdata,
  output logic        rd_wen,
  output logic        commit,
  output rv_trace_t   record,
  output logic        halted
);

  logic [31:0] alu, pc_plus4, br_target, next_pc, ld_shift, ld_val, b_op;
  logic [1:0]  off;
  logic        take_br;

  assign commit    = start && !halted && !stall;
  assign pc_plus4  = pc + 32'd4;
  assign br_target = pc + dec.imm;
  assign d_addr    = rs1_data + dec.imm;   // Also the JALR target
  assign off       = d_addr[1:0];
  assign b_op      = dec.imm;

  always_comb begin
    case (dec.op)
      OP_LUI:             alu = dec.imm;
      OP_AUIPC:           alu = br_target;
      OP_JAL, OP_JALR:    alu = pc_plus4;
      OP_ADDI:            alu = rs1_data + b_op;
      OP_SLTI:            alu = {31'd0, $signed(rs1_data) < $signed(b_op)};
      OP_SLTIU:           alu = {31'd0, rs1_data < b_op};
      OP_XORI:            alu = rs1_data ^ b_op;
      OP_ORI:             alu = rs1_data | b_op;
      OP_ANDI:            alu = rs1_data & b_op;
      OP_SLLI:            alu = rs1_data << b_op[4:0];
      OP_SRLI:            alu = rs1_data >> b_op[4:0];
      OP_SRAI:            alu = $signed(rs1_data) >>> b_op[4:0];
      OP_ADD:             alu = rs1_data + rs2_data;
      OP_SUB:             alu = rs1_data - rs2_data;
      OP_SLL:             alu = rs1_data << rs2_data[4:0];
      OP_SLT:             alu = {31'd0, $signed(rs1_data) < $signed(rs2_data)};
      OP_SLTU:            alu = {31'd0, rs1_data < rs2_data};
      OP_XOR:             alu = rs1_data ^ rs2_data;
      OP_SRL:             alu = rs1_data >> rs2_data[4:0];
      OP_SRA:             alu = $signed(rs1_data) >>> rs2_data[4:0];
      OP_OR:              alu = rs1_data | rs2_data;
      OP_AND:             alu = rs1_data & rs2_data;
      OP_CSRRW, OP_CSRRS: alu = csr_rdata;   // Old CSR value
      default:            alu = 32'd0;
    endcase
  end

  always_comb begin
    case (dec.op)
      OP_BEQ:  take_br = rs1_data == rs2_data;
      OP_BNE:  take_br = rs1_data != rs2_data;
      OP_BLT:  take_br = $signed(rs1_data) < $signed(rs2_data);
      OP_BGE:  take_br = $signed(rs1_data) >= $signed(rs2_data);
      OP_BLTU: take_br = rs1_data < rs2_data;
      OP_BGEU: take_br = rs1_data >= rs2_data;
      default: take_br = 1'b0;
    endcase
  end

  always_comb begin
    case (dec.op)
      OP_JAL:   next_pc = br_target;
      OP_JALR:  next_pc = {d_addr[31:1], 1'b0};
      OP_ECALL: next_pc = mtvec;
      OP_MRET:  next_pc = mepc;
      default:  next_pc = take_br ? br_target : pc_plus4;
    endcase
  end

  assign ld_shift = d_rdata >> {off, 3'b000};

  always_comb begin
    case (dec.op)
      OP_LB:   ld_val = {{24{ld_shift[7]}}, ld_shift[7:0]};
      OP_LH:   ld_val = {{16{ld_shift[15]}}, ld_shift[15:0]};
      OP_LBU:  ld_val = {24'd0, ld_shift[7:0]};
      OP_LHU:  ld_val = {16'd0, ld_shift[15:0]};
      default: ld_val = d_rdata;
    endcase
  end

  assign rd_wdata = dec.is_load ? ld_val : alu;
  assign rd_wen   = commit && dec.rd_wen;

  always_comb begin
    case (dec.op)
      OP_SB: begin
        d_wdata = {4{rs2_data[7:0]}};
        d_mask  = 4'b0001 << off;
      end
      OP_SH: begin
        d_wdata = {2{rs2_data[15:0]}};
        d_mask  = off[1] ? 4'b1100 : 4'b0011;
      end
      OP_SW: begin
        d_wdata = rs2_data;
        d_mask  = 4'b1111;
      end
      default: begin
        d_wdata = rs2_data;
        d_mask  = 4'b0000;
      end
    endcase
  end

  assign d_wen = commit && dec.is_store;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc     <= `RV_RESET_PC;
      halted <= 1'b0;
    end else if (commit) begin
      pc <= next_pc;
      if (dec.op == OP_EBREAK) begin
        halted <= 1'b1;
      end
    end
  end

  always_comb begin
    record          = '0;
    record.pc       = pc;
    record.inst     = inst;
    record.rd_wen   = dec.rd_wen;
    record.rd       = dec.rd;
    record.rd_wdata = dec.rd_wen ? rd_wdata : 32'd0;
    record.st_en    = dec.is_store;
    record.st_addr  = dec.is_store ? d_addr : 32'd0;
    record.st_wdata = dec.is_store ? d_wdata : 32'd0;
    record.st_mask  = d_mask;
    record.trap     = (dec.op == OP_ECALL) || (dec.op == OP_MRET);
  end

endmodule

`default_nettype wire

// File: hw/rv_trace_tx.sv
`default_nettype none
`timescale 1ns/1ps
`include "rv_params.svh"

module rv_trace_tx import rv_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      commit,
  input  rv_trace_t record,
  input  logic      credit_return,
  output logic      stall,
  output rv_trace_t trace,
  output logic      trace_valid
);

  localparam int unsigned CW = $clog2(`RV_TRACE_CREDITS + 1);

  logic [CW-1:0] credits;

  always_ff @(posedge clk) begin
    if (commit) begin
      trace <= record;
    end
  end

  // Credit is taken at commit so the record issued next cycle is covered
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      trace_valid <= 1'b0;
      credits     <= CW'(`RV_TRACE_CREDITS);
    end else begin
      trace_valid <= commit;
      case ({commit, credit_return})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: ;   // Both or neither cancel out
      endcase
    end
  end

  assign stall = (credits == '0);

endmodule

`default_nettype wire

// File: hw/rv_core_top.sv
`default_nettype none
`timescale 1ns/1ps

module rv_core_top import rv_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  rv_load_t  load,
  input  logic      start,
  input  logic      credit_return,
  output rv_trace_t trace,
  output logic      trace_valid,
  output logic      halted
);

  logic [31:0] pc, inst;
  logic [31:0] rs1_data, rs2_data;
  logic [31:0] csr_rdata, mepc, mtvec;
  logic [31:0] d_addr, d_rdata, d_wdata;
  logic [3:0]  d_mask;
  logic        d_wen;
  logic [31:0] rd_wdata;
  logic        rd_wen, commit, stall;
  rv_dec_t     dec;
  rv_trace_t   record;

  rv_mem u_mem (.clk, .load, .pc, .inst, .d_addr, .d_rdata, .d_wdata, .d_mask, .d_wen);

  rv_decode u_decode (.inst, .dec);

  rv_regfile u_regfile (
    .clk, .rst_n, .raddr1(dec.rs1), .raddr2(dec.rs2), .rdata1(rs1_data),
    .rdata2(rs2_data), .waddr(dec.rd), .wdata(rd_wdata), .wen(rd_wen)
  );

  rv_csr u_csr (.clk, .rst_n, .dec, .rs1_data, .pc, .commit, .csr_rdata, .mepc, .mtvec);

  rv_exec u_exec (
    .clk, .rst_n, .start, .stall, .inst, .dec, .rs1_data, .rs2_data, .csr_rdata,
    .mepc, .mtvec, .d_rdata, .pc, .d_addr, .d_wdata, .d_mask, .d_wen, .rd_wdata,
    .rd_wen, .commit, .record, .halted
  );

  rv_trace_tx u_trace_tx (
    .clk, .rst_n, .commit, .record, .credit_return, .stall, .trace, .trace_valid
  );

endmodule

`default_nettype wire

// File: testbench/tb_rv_model.svh
localparam int EBREAK_IDX  = 203;      // Word index of the halting EBREAK
localparam int HANDLER_IDX = 384;      // Trap handler at 0x600
localparam int DATA_IDX    = 448;      // Data region 0x700 to 0x7ff
localparam int MODEL_STEPS = 2000;

logic [31:0] rng_state;
logic [31:0] image [`RV_MEM_WORDS];
logic [31:0] m_mem [`RV_MEM_WORDS];
logic [31:0] m_reg [32];
logic [31:0] m_mstatus, m_mtvec, m_mepc, m_mcause;
rv_trace_t   exp_q [$];

function automatic logic [31:0] next_random();
  rng_state = rng_state ^ (rng_state << 13);
  rng_state = rng_state ^ (rng_state >> 17);
  rng_state = rng_state ^ (rng_state << 5);
  return rng_state;
endfunction

// One random instruction at word index k
// Branches and jumps only go forward
function automatic logic [31:0] random_inst(int k);
  logic [31:0] r, r2;
  logic [4:0]  rd, rs1, rs2;
  logic [2:0]  f3;
  logic [11:0] imm, csr;
  logic [7:0]  off;
  logic [12:0] off13;
  logic [20:0] off21;
  int          t;
  r     = next_random();
  r2    = next_random();
  rd    = 5'(32'd1 + (r2 % 32'd30));    // x31 stays the data base
  rs1   = r2[12:8];
  rs2   = r2[17:13];
  f3    = r2[20:18];
  imm   = r2[31:20];
  off   = r2[27:20];
  t     = k + 1 + int'(r2[7:6]);
  if (t > EBREAK_IDX) t = EBREAK_IDX;
  off13 = 13'((t - k) * 4);
  off21 = 21'((t - k) * 4);
  case (r[3:0])
    4'd0, 4'd1: return {r2[31:12], rd, r[4] ? 7'h37 : 7'h17};
    4'd2, 4'd3, 4'd4: begin
      if (f3 == 3'd1) imm = {7'd0, r2[24:20]};
      else if (f3 == 3'd5) imm = {1'b0, r[5], 5'd0, r2[24:20]};
      return {imm, rs1, f3, rd, 7'h13};
    end
    4'd5, 4'd6, 4'd7:
      return {1'b0, r[5] && (f3 == 3'd0 || f3 == 3'd5), 5'd0, rs2, rs1, f3, rd, 7'h33};
    4'd8, 4'd9: begin
      if (f3 == 3'd3) f3 = 3'd2;
      else if (f3[2:1] == 2'b11) f3 = f3 - 3'd2;
      if (f3[1:0] == 2'd2) off[1:0] = 2'b00;
      else if (f3[1:0] == 2'd1) off[0] = 1'b0;
      return {4'd0, off, 5'd31, f3, rd, 7'h03};
    end
    4'd10, 4'd11: begin
      f3 = (f3[1:0] == 2'd3) ? 3'd2 : {1'b0, f3[1:0]};
      if (f3 == 3'd2) off[1:0] = 2'b00;
      else if (f3 == 3'd1) off[0] = 1'b0;
      return {4'd0, off[7:5], rs2, 5'd31, f3, off[4:0], 7'h23};
    end
    4'd12: begin
      if (f3[2:1] == 2'b01) f3[2] = 1'b1;
      return {off13[12], off13[10:5], rs2, rs1, f3, off13[4:1], off13[11], 7'h63};
    end
    4'd13: begin
      if (r[4]) return {off21[20], off21[10:1], off21[11], off21[19:12], rd, 7'h6f};
      imm = 12'(t * 4) | {11'd0, r[5]};    // JALR clears bit 0
      return {imm, 5'd0, 3'd0, rd, 7'h67};
    end
    4'd14: begin
      case (r[6:4])
        3'd1:    csr = `RV_CSR_MTVEC;
        3'd2:    csr = `RV_CSR_MEPC;
        3'd3:    csr = `RV_CSR_MCAUSE;
        3'd4:    csr = 12'h340;    // Unimplemented CSR reads zero
        default: csr = `RV_CSR_MSTATUS;
      endcase
      if (csr == `RV_CSR_MTVEC) return {csr, 5'd0, 3'd2, rd, 7'h73};
      return {csr, rs1, r[7] ? 3'd1 : 3'd2, rd, 7'h73};
    end
    default: return 32'h0000_0073;    // ECALL
  endcase
endfunction

task automatic build_program();
  for (int i = 0; i < `RV_MEM_WORDS; i++) begin
    image[i] = 32'(i) * 32'h9e37_79b9 ^ 32'h5a5a_0000;
  end
  image[0] = {12'h600, 5'd0, 3'd0, 5'd5, 7'h13};
  image[1] = {`RV_CSR_MTVEC, 5'd5, 3'd1, 5'd0, 7'h73};
  image[2] = {12'h700, 5'd0, 3'd0, 5'd31, 7'h13};
  for (int k = 3; k < EBREAK_IDX; k++) begin
    image[k] = random_inst(k);
  end
  image[EBREAK_IDX]    = 32'h0010_0073;
  image[HANDLER_IDX]   = {`RV_CSR_MEPC, 5'd0, 3'd2, 5'd27, 7'h73};
  image[HANDLER_IDX+1] = {12'd4, 5'd27, 3'd0, 5'd27, 7'h13};
  image[HANDLER_IDX+2] = {`RV_CSR_MEPC, 5'd27, 3'd1, 5'd0, 7'h73};
  image[HANDLER_IDX+3] = 32'h3020_0073;
  for (int i = DATA_IDX; i < DATA_IDX + 64; i++) begin
    image[i] = next_random();
  end
endtask

function automatic logic [31:0] alu_ref(logic [2:0] f3, logic alt, logic [31:0] a,
                                        logic [31:0] b);
  case (f3)
    3'd0:    return alt ? a - b : a + b;
    3'd1:    return a << b[4:0];
    3'd2:    return {31'd0, $signed(a) < $signed(b)};
    3'd3:    return {31'd0, a < b};
    3'd4:    return a ^ b;
    3'd5:    return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
    3'd6:    return a | b;
    default: return a & b;
  endcase
endfunction

function automatic logic [31:0] csr_value(logic [11:0] addr);
  case (addr)
    `RV_CSR_MSTATUS: return m_mstatus;
    `RV_CSR_MTVEC:   return m_mtvec;
    `RV_CSR_MEPC:    return m_mepc;
    `RV_CSR_MCAUSE:  return m_mcause;
    default:         return 32'd0;
  endcase
endfunction

task automatic csr_update(logic [11:0] addr, logic [31:0] v);
  case (addr)
    `RV_CSR_MSTATUS: m_mstatus = v;
    `RV_CSR_MTVEC:   m_mtvec   = v;
    `RV_CSR_MEPC:    m_mepc    = v;
    `RV_CSR_MCAUSE:  m_mcause  = v;
    default: ;
  endcase
endtask

// Instruction set model that queues one record per executed instruction
task automatic run_model();
  logic [31:0] pc, inst, a, b, wv, npc, addr, word, sh, old, sdata;
  logic [31:0] immi, imms, immb, immj;
  logic [3:0]  smask;
  logic [2:0]  f3;
  logic        wb, take, done;
  rv_trace_t   rec;
  int          steps;
  for (int i = 0; i < `RV_MEM_WORDS; i++) m_mem[i] = image[i];
  for (int i = 0; i < 32; i++) m_reg[i] = 32'd0;
  m_mstatus = 32'h0000_1800;
  m_mtvec   = 32'd0;
  m_mepc    = 32'd0;
  m_mcause  = 32'd0;
  exp_q.delete();
  pc    = `RV_RESET_PC;
  done  = 1'b0;
  steps = 0;
  while (!done && steps < MODEL_STEPS) begin
    inst  = m_mem[pc[RV_MEM_AW+1:2]];
    f3    = inst[14:12];
    a     = m_reg[inst[19:15]];
    b     = m_reg[inst[24:20]];
    immi  = {{20{inst[31]}}, inst[31:20]};
    imms  = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    immb  = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    immj  = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
    rec      = '0;
    rec.pc   = pc;
    rec.inst = inst;
    rec.rd   = inst[11:7];
    npc   = pc + 32'd4;
    wb    = 1'b0;
    wv    = 32'd0;
    case (inst[6:0])
      7'h37: begin
        wb = 1'b1;
        wv = {inst[31:12], 12'd0};
      end
      7'h17: begin
        wb = 1'b1;
        wv = pc + {inst[31:12], 12'd0};
      end
      7'h6f: begin
        wb  = 1'b1;
        wv  = pc + 32'd4;
        npc = pc + immj;
      end
      7'h67: begin
        wb  = 1'b1;
        wv  = pc + 32'd4;
        npc = (a + immi) & ~32'd1;
      end
      7'h63: begin
        case (f3)
          3'd0:    take = a == b;
          3'd1:    take = a != b;
          3'd4:    take = $signed(a) < $signed(b);
          3'd5:    take = $signed(a) >= $signed(b);
          3'd6:    take = a < b;
          default: take = a >= b;
        endcase
        if (take) npc = pc + immb;
      end
      7'h03: begin
        addr = a + immi;
        word = m_mem[addr[RV_MEM_AW+1:2]];
        sh   = word >> {addr[1:0], 3'b000};
        wb   = 1'b1;
        case (f3)
          3'd0:    wv = {{24{sh[7]}}, sh[7:0]};
          3'd1:    wv = {{16{sh[15]}}, sh[15:0]};
          3'd4:    wv = {24'd0, sh[7:0]};
          3'd5:    wv = {16'd0, sh[15:0]};
          default: wv = word;
        endcase
      end
      7'h23: begin
        addr = a + imms;
        case (f3)
          3'd0: begin
            sdata = {4{b[7:0]}};
            smask = 4'b0001 << addr[1:0];
          end
          3'd1: begin
            sdata = {2{b[15:0]}};
            smask = addr[1] ? 4'b1100 : 4'b0011;
          end
          default: begin
            sdata = b;
            smask = 4'b1111;
          end
        endcase
        for (int j = 0; j < 4; j++) begin
          if (smask[j]) m_mem[addr[RV_MEM_AW+1:2]][8*j +: 8] = sdata[8*j +: 8];
        end
        rec.st_en    = 1'b1;
        rec.st_addr  = addr;
        rec.st_wdata = sdata;
        rec.st_mask  = smask;
      end
      7'h13: begin
        wb = 1'b1;
        wv = alu_ref(f3, inst[30] && f3 == 3'd5, a, immi);
      end
      7'h33: begin
        wb = 1'b1;
        wv = alu_ref(f3, inst[30], a, b);
      end
      default: begin
        if (inst == 32'h0000_0073) begin
          rec.trap  = 1'b1;
          npc       = m_mtvec;
          m_mepc    = pc;
          m_mcause  = 32'd11;
          m_mstatus = {m_mstatus[31:13], 2'b11, m_mstatus[10:8], m_mstatus[3],
                       m_mstatus[6:4], 1'b0, m_mstatus[2:0]};
        end else if (inst == 32'h3020_0073) begin
          rec.trap  = 1'b1;
          npc       = m_mepc;
          m_mstatus = {m_mstatus[31:8], 1'b1, m_mstatus[6:4], m_mstatus[7], m_mstatus[2:0]};
        end else if (inst == 32'h0010_0073) begin
          done = 1'b1;
        end else begin
          old = csr_value(inst[31:20]);
          wb  = 1'b1;
          wv  = old;
          csr_update(inst[31:20], (f3 == 3'd1) ? a : (old | a));
        end
      end
    endcase
    if (wb && inst[11:7] != 5'd0) begin
      rec.rd_wen   = 1'b1;
      rec.rd_wdata = wv;
      m_reg[inst[11:7]] = wv;
    end
    exp_q.push_back(rec);
    pc = npc;
    steps++;
  end
  if (!done) begin
    errors++;
    $display("Reference model did not reach EBREAK within %0d steps", steps);
  end
endtask

// File: testbench/tb_rv_core.sv
`default_nettype none
`timescale 1ns/1ps
`include "rv_params.svh"

module tb_rv_core import rv_pkg::*; ();

  logic      clk;
  logic      rst_n;
  logic      start;
  logic      credit_return;
  rv_load_t  load;
  rv_trace_t trace;
  logic      trace_valid;
  logic      halted;

  int errors;
  int checks;
  int issued;      // Records seen on trace_valid
  int returned;    // Credits handed back
  int exp_total;
  int limit;
  int cycle;
  int due_q [$];   // Cycle at which each credit goes back

  `include "tb_rv_model.svh"

  rv_core_top DUT (
    .clk, .rst_n, .load, .start, .credit_return, .trace, .trace_valid, .halted
  );

  always #50 clk = ~clk;

  task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error: %s = 0x%h, expected 0x%h (record %0d)", name, got, exp, issued);
    end
  endtask

  task automatic compare_record(rv_trace_t got);
    rv_trace_t exp;
    if (exp_q.size() == 0) begin
      errors++;
      $display("Record %0d arrived with no record left in the model's sequence", issued);
    end else begin
      exp = exp_q.pop_front();
      check_value("trace.pc", got.pc, exp.pc);
      check_value("trace.inst", got.inst, exp.inst);
      check_value("trace.rd_wen", 32'(got.rd_wen), 32'(exp.rd_wen));
      check_value("trace.rd", 32'(got.rd), 32'(exp.rd));
      check_value("trace.rd_wdata", got.rd_wdata, exp.rd_wdata);
      check_value("trace.st_en", 32'(got.st_en), 32'(exp.st_en));
      check_value("trace.st_addr", got.st_addr, exp.st_addr);
      check_value("trace.st_wdata", got.st_wdata, exp.st_wdata);
      check_value("trace.st_mask", 32'(got.st_mask), 32'(exp.st_mask));
      check_value("trace.trap", 32'(got.trap), 32'(exp.trap));
    end
  endtask

  // Trace consumer with a random credit delay of 0 to 3 cycles
  always @(posedge clk) begin
    if (credit_return) returned++;
    if (trace_valid) begin
      issued++;
      if (issued - returned > `RV_TRACE_CREDITS) begin
        errors++;
        $display("More than %0d records outstanding at record %0d", `RV_TRACE_CREDITS, issued);
      end
      due_q.push_back(cycle + int'(next_random() % 32'd4));
      compare_record(trace);
    end
    if (due_q.size() > 0 && due_q[0] <= cycle) begin
      void'(due_q.pop_front());
      credit_return <= 1'b1;
    end else begin
      credit_return <= 1'b0;
    end
  end

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (limit > 0 && cycle >= limit) begin
      $display("Timeout after %0d cycles with %0d of %0d records received, errors %0d",
               cycle, issued, exp_total, errors);
      $display("Some tests failed");
      $finish;
    end
  end

  initial begin
    clk           = 1'b0;
    rst_n         = 1'b0;
    start         = 1'b0;
    credit_return = 1'b0;
    load          = '0;
    errors        = 0;
    checks        = 0;
    issued        = 0;
    returned      = 0;
    cycle         = 0;
    limit         = 0;
    rng_state     = 32'd76;
    build_program();
    run_model();
    exp_total = exp_q.size();
    limit     = 10 + `RV_MEM_WORDS + exp_total * 5 + 200;

    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    check_value("halted", 32'(halted), 32'd0);
    check_value("trace_valid", 32'(trace_valid), 32'd0);

    for (int i = 0; i < `RV_MEM_WORDS; i++) begin
      @(posedge clk);
      load.valid <= 1'b1;
      load.addr  <= RV_MEM_AW'(i);
      load.data  <= image[i];
    end
    @(posedge clk);
    load  <= '0;
    start <= 1'b1;

    wait (issued >= exp_total);
    repeat (20) @(posedge clk);    // Any record after EBREAK shows up here
    check_value("halted", 32'(halted), 32'd1);
    check_value("record count", 32'(issued), 32'(exp_total));

    $display("Records %0d of %0d, checks %0d, errors %0d", issued, exp_total, checks, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
+incdir+hw
+incdir+testbench
hw/rv_pkg.sv
hw/rv_mem.sv
hw/rv_decode.sv
hw/rv_regfile.sv
hw/rv_csr.sv
hw/rv_exec.sv
hw/rv_trace_tx.sv
hw/rv_core_top.sv
testbench/tb_rv_core.sv

// File: run.sh
#!/bin/sh
# Builds the core testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f src.f --top-module tb_rv_core -o tb_rv_core
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/tb_rv_core)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "All tests passed"; then
  exit 0
fi
echo "Simulation did not report success"
exit 1
